/* design/lpif_defines.svh */
/*
 * LPIF link adapter constants
 * Lane geometry, flit width, delay counter width and register map
 */
`ifndef LPIF_DEFINES_SVH
`define LPIF_DEFINES_SVH

// PHY lane geometry
`define LPIF_LANES      4
`define LPIF_LANE_W     24
// Lane bits left for payload after the strobe bit
`define LPIF_LANE_PL_W  23

// Packed flit and delay counter
`define LPIF_FLIT_W     89
`define LPIF_DLY_W      16

// AXI4-Lite register offsets
`define REG_CTRL        8'h00
`define REG_DLY_X       8'h04
`define REG_DLY_Y       8'h08
`define REG_DLY_Z       8'h0C
`define REG_STATUS      8'h10

`endif

/* design/lpif_pkg.sv */
/*
 * LPIF link adapter types
 * Flit field vectors, lane and bus words, online controller states
 */
package lpif_pkg;

  `include "lpif_defines.svh"

  // Flit fields
  typedef logic [63:0] flit_data_t;
  typedef logic [15:0] crc_t;
  typedef logic [3:0]  lstate_t;
  typedef logic [1:0]  protid_t;

  // Packed flit and one PHY lane
  typedef logic [`LPIF_FLIT_W-1:0] link_word_t;
  typedef logic [`LPIF_LANE_W-1:0] lane_t;

  typedef logic [`LPIF_DLY_W-1:0] delay_t;

  // AXI4-Lite
  typedef logic [7:0]  axi_addr_t;
  typedef logic [31:0] axi_data_t;

  // Tx online sequencing
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_WAIT_Y,
    SYNC_WAIT_Z,
    SYNC_ONLINE
  } sync_state_t;

endpackage

/* design/lpif_cfg_if.sv */
/*
 * Configuration and sync status bundle between register block,
 * online controller and flit codec
 */
`timescale 1ns/10ps

interface lpif_cfg_if import lpif_pkg::*; ();

  logic   tx_online_req;
  logic   rx_online_req;
  delay_t delay_x;
  delay_t delay_y;
  delay_t delay_z;
  logic   tx_online_dly;
  logic   rx_online_dly;
  logic   rx_flit_seen;

  modport regs (output tx_online_req, rx_online_req, delay_x, delay_y, delay_z,
                input  tx_online_dly, rx_online_dly, rx_flit_seen);

  modport ctrl (input  tx_online_req, rx_online_req, delay_x, delay_y, delay_z,
                output tx_online_dly, rx_online_dly);

  modport codec (input rx_online_dly, output rx_flit_seen);

endinterface

/* design/lpif_cfg_regs.sv */
/*
 * AXI4-Lite register block
 * Online control bits, the three sync delays and link status
 */
`timescale 1ns/10ps

module lpif_cfg_regs import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  axi_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axi_data_t  wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axi_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output axi_data_t  rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,
  lpif_cfg_if.regs   cfg
);

  `include "lpif_defines.svh"

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        tx_req_q;
  logic        rx_req_q;
  delay_t      dly_x_q;
  delay_t      dly_y_q;
  delay_t      dly_z_q;
  logic [15:0] flit_cnt;
  logic        aw_hs;
  logic        ar_hs;
  logic        wr_ok;
  axi_data_t   rd_data;
  logic [1:0]  rd_resp;

  // Address and data taken together, one outstanding response
  assign aw_hs   = awvalid & wvalid & ~bvalid;
  assign awready = aw_hs;
  assign wready  = aw_hs;
  assign ar_hs   = arvalid & ~rvalid;
  assign arready = ar_hs;

  assign cfg.tx_online_req = tx_req_q;
  assign cfg.rx_online_req = rx_req_q;
  assign cfg.delay_x       = dly_x_q;
  assign cfg.delay_y       = dly_y_q;
  assign cfg.delay_z       = dly_z_q;

  // Status is mapped but read only
  always_comb begin
    case (awaddr)
      `REG_CTRL, `REG_DLY_X, `REG_DLY_Y, `REG_DLY_Z, `REG_STATUS: wr_ok = 1'b1;
      default: wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      `REG_CTRL:   rd_data = {30'b0, rx_req_q, tx_req_q};
      `REG_DLY_X:  rd_data = {{(32-`LPIF_DLY_W){1'b0}}, dly_x_q};
      `REG_DLY_Y:  rd_data = {{(32-`LPIF_DLY_W){1'b0}}, dly_y_q};
      `REG_DLY_Z:  rd_data = {{(32-`LPIF_DLY_W){1'b0}}, dly_z_q};
      `REG_STATUS: rd_data = {flit_cnt, 14'b0, cfg.rx_online_dly, cfg.tx_online_dly};
      default:     rd_resp = RESP_SLVERR;
    endcase
  end

  //////////////////////////////////////////////////
  // Write channel and config registers
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_req_q <= 1'b0;
      rx_req_q <= 1'b0;
      dly_x_q  <= '0;
      dly_y_q  <= '0;
      dly_z_q  <= '0;
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
    end else begin
      if (aw_hs) begin
        case (awaddr)
          `REG_CTRL: begin
            tx_req_q <= wdata[0];
            rx_req_q <= wdata[1];
          end
          `REG_DLY_X: dly_x_q <= wdata[`LPIF_DLY_W-1:0];
          `REG_DLY_Y: dly_y_q <= wdata[`LPIF_DLY_W-1:0];
          `REG_DLY_Z: dly_z_q <= wdata[`LPIF_DLY_W-1:0];
          default: ;
        endcase
        bvalid <= 1'b1;
        bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read channel and flit counter
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rvalid   <= 1'b0;
      flit_cnt <= '0;
    end else begin
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      // Wraps silently
      if (cfg.rx_flit_seen) begin
        flit_cnt <= flit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (ar_hs) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

endmodule

/* design/lpif_online_ctrl.sv */
/*
 * Online controller
 * Holds tx back by delay_y then delay_z and rx back by delay_x
 */
`timescale 1ns/10ps

module lpif_online_ctrl import lpif_pkg::*; (
  input  logic     clk_wr,
  input  logic     rst_n,
  lpif_cfg_if.ctrl cfg,
  output logic     tx_online_dly,
  output logic     stb_en
);

  sync_state_t tx_state;
  delay_t      tx_cnt;
  delay_t      rx_cnt;
  logic        rx_dly;
  logic        tx_on;

  assign tx_on             = (tx_state == SYNC_ONLINE);
  assign tx_online_dly     = tx_on;
  assign cfg.tx_online_dly = tx_on;
  // Persistent strobe
  assign stb_en            = tx_on;
  assign cfg.rx_online_dly = rx_dly;

  //////////////////////////////////////////////////
  // Tx sequencing
  // Leaving idle already uses up one cycle of the total delay
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= SYNC_IDLE;
      tx_cnt   <= '0;
    end else if (!cfg.tx_online_req) begin
      tx_state <= SYNC_IDLE;
    end else begin
      case (tx_state)
        SYNC_IDLE: begin
          if (cfg.delay_y > 1) begin
            tx_state <= SYNC_WAIT_Y;
            tx_cnt   <= cfg.delay_y - 1'b1;
          end else if (cfg.delay_y == 1 && cfg.delay_z != 0) begin
            tx_state <= SYNC_WAIT_Z;
            tx_cnt   <= cfg.delay_z;
          end else if (cfg.delay_y == 0 && cfg.delay_z > 1) begin
            tx_state <= SYNC_WAIT_Z;
            tx_cnt   <= cfg.delay_z - 1'b1;
          end else begin
            tx_state <= SYNC_ONLINE;
          end
        end
        SYNC_WAIT_Y: begin
          if (tx_cnt > 1) begin
            tx_cnt <= tx_cnt - 1'b1;
          end else if (cfg.delay_z != 0) begin
            tx_state <= SYNC_WAIT_Z;
            tx_cnt   <= cfg.delay_z;
          end else begin
            tx_state <= SYNC_ONLINE;
          end
        end
        SYNC_WAIT_Z: begin
          if (tx_cnt > 1) begin
            tx_cnt <= tx_cnt - 1'b1;
          end else begin
            tx_state <= SYNC_ONLINE;
          end
        end
        default: tx_state <= SYNC_ONLINE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Rx delay, reloaded while offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt <= '0;
      rx_dly <= 1'b0;
    end else if (!cfg.rx_online_req) begin
      rx_cnt <= cfg.delay_x;
      rx_dly <= 1'b0;
    end else if (!rx_dly) begin
      if (rx_cnt > 1) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_dly <= 1'b1;
      end
    end
  end

endmodule

/* design/lpif_flit_codec.sv */
/*
 * Flit codec
 * Packs upstream flit fields into a link word, unpacks received words
 */
`timescale 1ns/10ps

module lpif_flit_codec import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  lstate_t    ustrm_state,
  input  protid_t    ustrm_protid,
  input  flit_data_t ustrm_data,
  input  logic       ustrm_dvalid,
  input  crc_t       ustrm_crc,
  input  logic       ustrm_crc_valid,
  input  logic       ustrm_valid,
  output lstate_t    dstrm_state,
  output protid_t    dstrm_protid,
  output flit_data_t dstrm_data,
  output logic       dstrm_dvalid,
  output crc_t       dstrm_crc,
  output logic       dstrm_crc_valid,
  output logic       dstrm_valid,
  output link_word_t tx_word,
  input  link_word_t rx_word,
  lpif_cfg_if.codec  cfg
);

  // Data at the bottom, valid at the top
  assign tx_word = {ustrm_valid, ustrm_crc_valid, ustrm_dvalid, ustrm_protid,
                    ustrm_state, ustrm_crc, ustrm_data};

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_data      <= '0;
      dstrm_crc       <= '0;
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
      dstrm_valid     <= 1'b0;
    end else if (cfg.rx_online_dly) begin
      dstrm_data      <= rx_word[63:0];
      dstrm_crc       <= rx_word[79:64];
      dstrm_state     <= rx_word[83:80];
      dstrm_protid    <= rx_word[85:84];
      dstrm_dvalid    <= rx_word[86];
      dstrm_crc_valid <= rx_word[87];
      dstrm_valid     <= rx_word[88];
    end else begin
      // Offline, downstream sees nothing
      dstrm_data      <= '0;
      dstrm_crc       <= '0;
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
      dstrm_valid     <= 1'b0;
    end
  end

  // One pulse per delivered flit
  assign cfg.rx_flit_seen = dstrm_valid;

endmodule

/* design/lpif_lane_stripe.sv */
/*
 * Lane striper
 * Spreads the link word over four strobed PHY lanes and gathers it back
 */
`timescale 1ns/10ps

module lpif_lane_stripe import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  logic       tx_online,
  input  logic       stb_en,
  input  link_word_t tx_word,
  output link_word_t rx_word,
  output lane_t      tx_phy0,
  output lane_t      tx_phy1,
  output lane_t      tx_phy2,
  output lane_t      tx_phy3,
  input  lane_t      rx_phy0,
  input  lane_t      rx_phy1,
  input  lane_t      rx_phy2,
  input  lane_t      rx_phy3
);

  `include "lpif_defines.svh"

  localparam int PL_W = `LPIF_LANES * `LPIF_LANE_PL_W;

  logic [PL_W-1:0] tx_pl;
  logic [PL_W-1:0] rx_pl;
  lane_t           tx_lane_q [`LPIF_LANES];
  lane_t           rx_lane_q [`LPIF_LANES];
  lane_t           rx_phy_a  [`LPIF_LANES];

  // Spare top bits ride as zero
  assign tx_pl = {{(PL_W-`LPIF_FLIT_W){1'b0}}, tx_word};

  //////////////////////////////////////////////////
  // Transmit lanes, strobe in the top bit
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < `LPIF_LANES; n++) begin
        tx_lane_q[n] <= '0;
      end
    end else begin
      for (int n = 0; n < `LPIF_LANES; n++) begin
        if (tx_online) begin
          tx_lane_q[n] <= {stb_en, tx_pl[n*`LPIF_LANE_PL_W +: `LPIF_LANE_PL_W]};
        end else begin
          tx_lane_q[n] <= '0;
        end
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  //////////////////////////////////////////////////
  // Receive lanes, strobe dropped
  assign rx_phy_a = '{rx_phy0, rx_phy1, rx_phy2, rx_phy3};

  always_ff @(posedge clk_wr) begin
    rx_lane_q <= rx_phy_a;
  end

  always_comb begin
    for (int n = 0; n < `LPIF_LANES; n++) begin
      rx_pl[n*`LPIF_LANE_PL_W +: `LPIF_LANE_PL_W] = rx_lane_q[n][`LPIF_LANE_PL_W-1:0];
    end
  end

  assign rx_word = rx_pl[`LPIF_FLIT_W-1:0];

endmodule

/* design/lpif_link_top.sv */
/*
 * LPIF link adapter top
 * Register block, online controller, flit codec and lane striper
 */
`timescale 1ns/10ps

module lpif_link_top import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst_n,

  // AXI4-Lite configuration
  input  axi_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axi_data_t  wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axi_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output axi_data_t  rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  // Upstream flit
  input  lstate_t    ustrm_state,
  input  protid_t    ustrm_protid,
  input  flit_data_t ustrm_data,
  input  logic       ustrm_dvalid,
  input  crc_t       ustrm_crc,
  input  logic       ustrm_crc_valid,
  input  logic       ustrm_valid,

  // Downstream flit
  output lstate_t    dstrm_state,
  output protid_t    dstrm_protid,
  output flit_data_t dstrm_data,
  output logic       dstrm_dvalid,
  output crc_t       dstrm_crc,
  output logic       dstrm_crc_valid,
  output logic       dstrm_valid,

  // PHY lanes
  output lane_t      tx_phy0,
  output lane_t      tx_phy1,
  output lane_t      tx_phy2,
  output lane_t      tx_phy3,
  input  lane_t      rx_phy0,
  input  lane_t      rx_phy1,
  input  lane_t      rx_phy2,
  input  lane_t      rx_phy3
);

  link_word_t tx_word;
  link_word_t rx_word;
  logic       tx_online_dly;
  logic       stb_en;

  lpif_cfg_if cfg_if ();

  //////////////////////////////////////////////////
  // Configuration
  lpif_cfg_regs u_cfg_regs (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cfg     (cfg_if.regs)
  );

  lpif_online_ctrl u_online_ctrl (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .cfg           (cfg_if.ctrl),
    .tx_online_dly (tx_online_dly),
    .stb_en        (stb_en)
  );

  //////////////////////////////////////////////////
  // Data path
  lpif_flit_codec u_flit_codec (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .cfg             (cfg_if.codec)
  );

  lpif_lane_stripe u_lane_stripe (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .tx_online (tx_online_dly),
    .stb_en    (stb_en),
    .tx_word   (tx_word),
    .rx_word   (rx_word),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .tx_phy2   (tx_phy2),
    .tx_phy3   (tx_phy3),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .rx_phy2   (rx_phy2),
    .rx_phy3   (rx_phy3)
  );

endmodule

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * 4 ns clock, rst_n held low for the first 8 rising edges
 */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tests/tb_lpif_link.sv */
/*
 * LPIF link adapter testbench
 * AXI4-Lite setup, tx/rx online sequencing, PHY loopback with a
 * reference lane model and an in-order flit checker
 */
`timescale 1ns/10ps

module tb_lpif_link import lpif_pkg::*; ();

  `include "lpif_defines.svh"

  localparam logic [1:0]  OKAY    = 2'b00;
  localparam logic [1:0]  SLVERR  = 2'b10;
  localparam int unsigned DLY_X   = 9;
  localparam int unsigned DLY_Y   = 5;
  localparam int unsigned DLY_Z   = 7;
  localparam int unsigned N_FLITS = 200;

  // Cycle budget per test, AXI accesses take at most about 16 cycles
  localparam int unsigned REG_CYC  = 12 * 16;
  localparam int unsigned TXON_CYC = 60;
  localparam int unsigned GATE_CYC = 20 + 8 * 16 + 40;
  localparam int unsigned LOOP_CYC = N_FLITS + 40;
  localparam int unsigned OFF_CYC  = 40;
  localparam int unsigned WD_CYC   = 8 + REG_CYC + TXON_CYC + GATE_CYC + LOOP_CYC
                                     + OFF_CYC + 200;

  typedef struct packed {
    logic       valid;
    logic       crc_valid;
    logic       dvalid;
    protid_t    protid;
    lstate_t    state;
    crc_t       crc;
    flit_data_t data;
  } flit_t;

  logic       clk;
  logic       rst_n;
  axi_addr_t  awaddr;
  logic       awvalid;
  logic       awready;
  axi_data_t  wdata;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axi_addr_t  araddr;
  logic       arvalid;
  logic       arready;
  axi_data_t  rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  lstate_t    ustrm_state;
  protid_t    ustrm_protid;
  flit_data_t ustrm_data;
  logic       ustrm_dvalid;
  crc_t       ustrm_crc;
  logic       ustrm_crc_valid;
  logic       ustrm_valid;
  lstate_t    dstrm_state;
  protid_t    dstrm_protid;
  flit_data_t dstrm_data;
  logic       dstrm_dvalid;
  crc_t       dstrm_crc;
  logic       dstrm_crc_valid;
  logic       dstrm_valid;
  lane_t      tx_phy0;
  lane_t      tx_phy1;
  lane_t      tx_phy2;
  lane_t      tx_phy3;
  lane_t      rx_phy0;
  lane_t      rx_phy1;
  lane_t      rx_phy2;
  lane_t      rx_phy3;

  integer      seed = 32'h90bb_73fe;
  int unsigned cyc;
  int unsigned aw_cyc;
  event        aw_done;
  flit_t       sent_q[$];
  int unsigned due_q[$];

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lpif_link_top dut (
    .clk_wr (clk), .rst_n (rst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid),
    .ustrm_data (ustrm_data), .ustrm_dvalid (ustrm_dvalid),
    .ustrm_crc (ustrm_crc), .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid (ustrm_valid),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid),
    .dstrm_data (dstrm_data), .dstrm_dvalid (dstrm_dvalid),
    .dstrm_crc (dstrm_crc), .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid (dstrm_valid),
    .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1), .tx_phy2 (tx_phy2), .tx_phy3 (tx_phy3),
    .rx_phy0 (rx_phy0), .rx_phy1 (rx_phy1), .rx_phy2 (rx_phy2), .rx_phy3 (rx_phy3)
  );

  // PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  // Edge counter, read before its own update at each rising edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  function automatic lane_t lane_ref(input flit_t f, input int n);
    logic [`LPIF_LANES*(`LPIF_LANE_W-1)-1:0] pl;
    // Data at bit 0, valid at bit 88, three spare bits on top
    pl = {3'b000, f.valid, f.crc_valid, f.dvalid, f.protid, f.state, f.crc, f.data};
    return {1'b1, pl[n*(`LPIF_LANE_W-1) +: (`LPIF_LANE_W-1)]};
  endfunction

  function automatic axi_data_t status_word(input logic tx, input logic rx,
                                            input logic [15:0] cnt);
    return {cnt, 14'b0, rx, tx};
  endfunction

  function automatic flit_t rand_flit();
    flit_t       f;
    logic [31:0] r;
    f.data[31:0]  = $random(seed);
    f.data[63:32] = $random(seed);
    r             = $random(seed);
    f.crc         = r[15:0];
    f.state       = r[19:16];
    f.protid      = r[21:20];
    f.dvalid      = r[22];
    f.crc_valid   = r[23];
    f.valid       = r[24];
    return f;
  endfunction

  function automatic int unsigned rand_delay();
    logic [31:0] r;
    r = $random(seed);
    return {30'b0, r[1:0]};
  endfunction

  function automatic flit_t read_dstrm();
    flit_t f;
    f.state     = dstrm_state;
    f.protid    = dstrm_protid;
    f.data      = dstrm_data;
    f.dvalid    = dstrm_dvalid;
    f.crc       = dstrm_crc;
    f.crc_valid = dstrm_crc_valid;
    f.valid     = dstrm_valid;
    return f;
  endfunction

  function automatic logic tx_lanes_zero();
    return (tx_phy0 == '0) && (tx_phy1 == '0) && (tx_phy2 == '0) && (tx_phy3 == '0);
  endfunction

  task automatic drive_flit(input flit_t f);
    ustrm_state     <= f.state;
    ustrm_protid    <= f.protid;
    ustrm_data      <= f.data;
    ustrm_dvalid    <= f.dvalid;
    ustrm_crc       <= f.crc;
    ustrm_crc_valid <= f.crc_valid;
    ustrm_valid     <= f.valid;
  endtask

  //////////////////////////////////////////////////
  // Error reporting and compare tasks
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_axi(input string name, input axi_data_t exp, input axi_data_t act,
                           input logic [1:0] exp_resp, input logic [1:0] act_resp);
    if (act !== exp || act_resp !== exp_resp) begin
      stop_on_error($sformatf("Fail %s: expected %h resp %b, actual %h resp %b",
                              name, exp, exp_resp, act, act_resp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp,
                            input logic [1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act != exp) begin
      stop_on_error($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                           output logic [1:0] resp);
    int unsigned tries;
    logic        got;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    tries = 0;
    do begin
      @(negedge clk);
      got = awready & wready;
      @(posedge clk);
      tries++;
      if (!got && tries > 50) stop_on_error("AXI write address and data never accepted");
    end while (!got);
    aw_cyc = cyc;
    -> aw_done;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (rand_delay()) @(posedge clk);
    bready <= 1'b1;
    tries = 0;
    do begin
      @(negedge clk);
      got  = bvalid;
      resp = bresp;
      @(posedge clk);
      tries++;
      if (!got && tries > 50) stop_on_error("AXI write response never arrived");
    end while (!got);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                          output logic [1:0] resp);
    int unsigned tries;
    logic        got;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    tries = 0;
    do begin
      @(negedge clk);
      got = arready;
      @(posedge clk);
      tries++;
      if (!got && tries > 50) stop_on_error("AXI read address never accepted");
    end while (!got);
    arvalid <= 1'b0;
    repeat (rand_delay()) @(posedge clk);
    rready <= 1'b1;
    tries = 0;
    do begin
      @(negedge clk);
      got  = rvalid;
      data = rdata;
      resp = rresp;
      @(posedge clk);
      tries++;
      if (!got && tries > 50) stop_on_error("AXI read data never arrived");
    end while (!got);
    rready <= 1'b0;
  endtask

  task automatic write_expect(input string name, input axi_addr_t addr,
                              input axi_data_t data, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_resp(name, exp_resp, resp);
  endtask

  task automatic read_expect(input string name, input axi_addr_t addr,
                             input axi_data_t exp);
    axi_data_t  data;
    logic [1:0] resp;
    axi_read(addr, data, resp);
    check_axi(name, exp, data, OKAY, resp);
  endtask

  //////////////////////////////////////////////////
  // Loopback checker, each flit is due three edges after it was driven
  always @(negedge clk) begin
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      check_flit("loopback flit", sent_q.pop_front(), read_dstrm());
      void'(due_q.pop_front());
    end
  end

  initial begin
    repeat (WD_CYC) @(posedge clk);
    stop_on_error("Watchdog expired before the tests finished");
  end

  initial begin
    flit_t       f;
    axi_data_t   rd;
    logic [1:0]  resp;
    int unsigned h;
    int unsigned lim;
    logic [15:0] exp_valid_cnt;

    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    drive_flit('0);
    @(posedge rst_n);
    repeat (2) @(posedge clk);

    // Register access
    read_expect("status after reset", `REG_STATUS, status_word(1'b0, 1'b0, 16'h0));
    write_expect("write dly_x", `REG_DLY_X, axi_data_t'(DLY_X), OKAY);
    write_expect("write dly_y", `REG_DLY_Y, axi_data_t'(DLY_Y), OKAY);
    write_expect("write dly_z", `REG_DLY_Z, axi_data_t'(DLY_Z), OKAY);
    read_expect("read dly_x", `REG_DLY_X, axi_data_t'(DLY_X));
    read_expect("read dly_y", `REG_DLY_Y, axi_data_t'(DLY_Y));
    read_expect("read dly_z", `REG_DLY_Z, axi_data_t'(DLY_Z));
    axi_read(8'h14, rd, resp);
    check_resp("read unmapped", SLVERR, resp);
    write_expect("write unmapped", 8'h20, 32'hdead_beef, SLVERR);
    write_expect("write status", `REG_STATUS, 32'hffff_ffff, OKAY);
    read_expect("status after write", `REG_STATUS, status_word(1'b0, 1'b0, 16'h0));

    // Tx online sequencing and striping
    f = rand_flit();
    @(posedge clk);
    drive_flit(f);
    fork
      begin
        write_expect("ctrl tx on", `REG_CTRL, 32'h1, OKAY);
        read_expect("status before tx online", `REG_STATUS,
                    status_word(1'b0, 1'b0, 16'h0));
      end
      begin
        @(aw_done);
        h = aw_cyc;
        lim = 0;
        do begin
          @(negedge clk);
          lim++;
          if (lim > 40) stop_on_error("tx_phy stayed zero after the tx online request");
        end while (tx_lanes_zero());
        // One extra edge for the stripe register, one for the counter convention
        check_count("tx online latency", DLY_Y + DLY_Z, cyc - h - 2);
        check_lane("tx_phy0", lane_ref(f, 0), tx_phy0);
        check_lane("tx_phy1", lane_ref(f, 1), tx_phy1);
        check_lane("tx_phy2", lane_ref(f, 2), tx_phy2);
        check_lane("tx_phy3", lane_ref(f, 3), tx_phy3);
      end
    join
    read_expect("status tx online", `REG_STATUS, status_word(1'b1, 1'b0, 16'h0));

    // Rx gated while offline
    repeat (20) begin
      @(posedge clk);
      drive_flit(rand_flit());
      @(negedge clk);
      check_flit("dstrm while rx offline", '0, read_dstrm());
    end
    @(posedge clk);
    drive_flit('0);
    write_expect("ctrl rx on", `REG_CTRL, 32'h3, OKAY);
    lim = 0;
    do begin
      axi_read(`REG_STATUS, rd, resp);
      lim++;
      if (lim > 20) stop_on_error("Rx online bit never appeared in status");
    end while (!rd[1]);
    check_axi("status rx online", status_word(1'b1, 1'b1, 16'h0), rd, OKAY, resp);

    // Loopback stream
    exp_valid_cnt = '0;
    for (int i = 0; i < N_FLITS; i++) begin
      @(posedge clk);
      f = rand_flit();
      drive_flit(f);
      sent_q.push_back(f);
      due_q.push_back(cyc + 4);
      if (f.valid) exp_valid_cnt = exp_valid_cnt + 16'd1;
    end
    @(posedge clk);
    drive_flit('0);
    lim = 0;
    while (due_q.size() > 0) begin
      @(negedge clk);
      lim++;
      if (lim > 20) stop_on_error("Loopback flits did not all arrive");
    end
    read_expect("status flit count", `REG_STATUS, status_word(1'b1, 1'b1, exp_valid_cnt));

    // Going offline
    f = rand_flit();
    f.valid = 1'b1;
    @(posedge clk);
    drive_flit(f);
    fork
      write_expect("ctrl off", `REG_CTRL, 32'h0, OKAY);
      begin
        @(aw_done);
        h = aw_cyc;
        while (cyc != h + 3) @(negedge clk);
        check_lane("offline tx_phy0", '0, tx_phy0);
        check_lane("offline tx_phy1", '0, tx_phy1);
        check_lane("offline tx_phy2", '0, tx_phy2);
        check_lane("offline tx_phy3", '0, tx_phy3);
        check_flit("offline dstrm", '0, read_dstrm());
      end
    join

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/lpif_pkg.sv
design/lpif_cfg_if.sv
design/lpif_cfg_regs.sv
design/lpif_online_ctrl.sv
design/lpif_flit_codec.sv
design/lpif_lane_stripe.sv
design/lpif_link_top.sv
tests/tb_clk_gen.sv
tests/tb_lpif_link.sv

/* run_sim.sh */
#!/bin/sh
# Build the LPIF link testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_lpif_link \
  -Mdir obj_dir -o tb_lpif_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_lpif_link > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
